// File: logic/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    typedef logic [15:0] addr_t;            // Byte address
    typedef logic [7:0]  data_t;            // Bus byte

    localparam data_t zp_page = 8'h00;      // High byte of zero page

    // One request on the split bus per cycle
    typedef struct packed {
        addr_t addr;                        // Read or write address
        data_t wdata;                       // Write bus
        logic  we;                          // Write strobe
    } mem_req_t;

endpackage

`default_nettype wire

// File: logic/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [7:0] opcode_t;           // Raw opcode byte

    localparam opcode_t OPC_TAX     = 8'hAA;
    localparam opcode_t OPC_TXA     = 8'h8A;
    localparam opcode_t OPC_TAY     = 8'hA8;
    localparam opcode_t OPC_TYA     = 8'h98;
    localparam opcode_t OPC_INX     = 8'hE8;
    localparam opcode_t OPC_INY     = 8'hC8;
    localparam opcode_t OPC_DEX     = 8'hCA;
    localparam opcode_t OPC_DEY     = 8'h88;
    localparam opcode_t OPC_CLC     = 8'h18;
    localparam opcode_t OPC_SEC     = 8'h38;
    localparam opcode_t OPC_LDA_IMM = 8'hA9;
    localparam opcode_t OPC_LDX_IMM = 8'hA2;
    localparam opcode_t OPC_LDY_IMM = 8'hA0;
    localparam opcode_t OPC_ORA_IMM = 8'h09;
    localparam opcode_t OPC_AND_IMM = 8'h29;
    localparam opcode_t OPC_EOR_IMM = 8'h49;
    localparam opcode_t OPC_ADC_IMM = 8'h69;
    localparam opcode_t OPC_SBC_IMM = 8'hE9;
    localparam opcode_t OPC_CMP_IMM = 8'hC9;
    localparam opcode_t OPC_LDA_ZP  = 8'hA5;
    localparam opcode_t OPC_LDX_ZP  = 8'hA6;
    localparam opcode_t OPC_LDY_ZP  = 8'hA4;
    localparam opcode_t OPC_STA_ZP  = 8'h85;
    localparam opcode_t OPC_STX_ZP  = 8'h86;
    localparam opcode_t OPC_STY_ZP  = 8'h84;
    localparam opcode_t OPC_JMP_ABS = 8'h4C;

    typedef enum logic [1:0] {SEL_A = 2'd0, SEL_X = 2'd1, SEL_Y = 2'd2} reg_sel_t;

    // Bits 3:2 pick the adder B term, bits 1:0 the logic function
    typedef enum logic [3:0] {
        OP_ADD = 4'b0011,
        OP_SUB = 4'b0111,
        OP_OR  = 4'b1100,
        OP_AND = 4'b1101,
        OP_EOR = 4'b1110,
        OP_A   = 4'b1111
    } alu_op_t;

    typedef enum logic [2:0] {DECODE, FETCH, REG, ZP0, JMP0, JMP1} state_t;

    typedef struct packed {
        state_t   next;                     // First state after DECODE
        logic     load_reg;                 // Result goes to register file
        logic     store;                    // STA/STX/STY
        logic     load_only;                // LDA/LDX/LDY, A input forced to 0
        logic     compare;                  // CMP
        reg_sel_t src_reg;
        reg_sel_t dst_reg;
        alu_op_t  op;
        logic     inc;                      // Carry in for REG state
        logic     set_c;                    // SEC
        logic     clr_c;                    // CLC
    } ctrl_t;

endpackage

`default_nettype wire

// File: logic/instr_decode.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decode (
    input  cpu_bus_pkg::data_t rdata,       // Opcode in DECODE
    output cpu_isa_pkg::ctrl_t dec
);

    logic known;                            // Opcode is in the supported set

    assign known = rdata inside {
        cpu_isa_pkg::OPC_TAX, cpu_isa_pkg::OPC_TXA, cpu_isa_pkg::OPC_TAY,
        cpu_isa_pkg::OPC_TYA, cpu_isa_pkg::OPC_INX, cpu_isa_pkg::OPC_INY,
        cpu_isa_pkg::OPC_DEX, cpu_isa_pkg::OPC_DEY, cpu_isa_pkg::OPC_CLC,
        cpu_isa_pkg::OPC_SEC, cpu_isa_pkg::OPC_LDA_IMM, cpu_isa_pkg::OPC_LDX_IMM,
        cpu_isa_pkg::OPC_LDY_IMM, cpu_isa_pkg::OPC_ORA_IMM, cpu_isa_pkg::OPC_AND_IMM,
        cpu_isa_pkg::OPC_EOR_IMM, cpu_isa_pkg::OPC_ADC_IMM, cpu_isa_pkg::OPC_SBC_IMM,
        cpu_isa_pkg::OPC_CMP_IMM, cpu_isa_pkg::OPC_LDA_ZP, cpu_isa_pkg::OPC_LDX_ZP,
        cpu_isa_pkg::OPC_LDY_ZP, cpu_isa_pkg::OPC_STA_ZP, cpu_isa_pkg::OPC_STX_ZP,
        cpu_isa_pkg::OPC_STY_ZP, cpu_isa_pkg::OPC_JMP_ABS
    };

    always_comb begin
        casez (rdata)                                           // Addressing mode
            8'b0100_1100: dec.next = cpu_isa_pkg::JMP0;         // JMP abs
            8'b10?0_01??: dec.next = cpu_isa_pkg::ZP0;          // LDx/STx zp
            8'b1??0_00?0,                                       // LDX/LDY #imm
            8'b???0_1001: dec.next = cpu_isa_pkg::FETCH;        // Column 9 #imm
            default:      dec.next = cpu_isa_pkg::REG;          // Implied
        endcase

        casez (rdata)
            8'b0???_??01,                                       // ORA AND EOR ADC
            8'b1?1?_??01,                                       // LDA SBC
            8'b1010_???0,                                       // LDX LDY TAX TAY
            8'b100?_10?0,                                       // DEY TXA TYA
            8'b1100_1010,                                       // DEX
            8'b???0_1000: dec.load_reg = 1'b1;                  // INX INY
            default:      dec.load_reg = 1'b0;
        endcase

        casez (rdata)
            8'b1110_1000, 8'b1100_1010,                         // INX DEX
            8'b101?_??10: dec.dst_reg = cpu_isa_pkg::SEL_X;     // LDX TAX
            8'b1?00_1000,                                       // DEY INY
            8'b101?_?100,                                       // LDY zp
            8'b1010_?000: dec.dst_reg = cpu_isa_pkg::SEL_Y;     // LDY #imm, TAY
            default:      dec.dst_reg = cpu_isa_pkg::SEL_A;
        endcase

        casez (rdata)
            8'b100?_?110,                                       // STX
            8'b100?_1?10,                                       // TXA
            8'b1110_??00, 8'b1100_1010:                         // INX DEX
                          dec.src_reg = cpu_isa_pkg::SEL_X;
            8'b100?_?100,                                       // STY
            8'b1001_1000,                                       // TYA
            8'b1?00_1000: dec.src_reg = cpu_isa_pkg::SEL_Y;     // DEY INY
            default:      dec.src_reg = cpu_isa_pkg::SEL_A;
        endcase

        casez (rdata)
            8'b1000_1000, 8'b1100_1010,                         // DEY DEX
            8'b11??_??01: dec.op = cpu_isa_pkg::OP_SUB;         // CMP SBC
            8'b010?_??01,                                       // EOR
            8'b00??_??01: dec.op = cpu_isa_pkg::alu_op_t'({2'b11, rdata[6:5]});
            default:      dec.op = cpu_isa_pkg::OP_ADD;         // Loads, ADC, INx
        endcase

        dec.store     = (rdata ==? 8'b100?_?1?0) || (rdata ==? 8'b100?_??01);
        dec.load_only = (rdata ==? 8'b101?_????);
        dec.compare   = (rdata ==? 8'b110?_??01);
        dec.inc       = (rdata ==? 8'b11?0_1000);               // INX INY
        dec.set_c     = (rdata == cpu_isa_pkg::OPC_SEC);
        dec.clr_c     = (rdata == cpu_isa_pkg::OPC_CLC);

        if (!known) begin                                       // Two-cycle NOP
            dec.next     = cpu_isa_pkg::REG;
            dec.load_reg = 1'b0;
            dec.store    = 1'b0;
            dec.compare  = 1'b0;
            dec.op       = cpu_isa_pkg::OP_A;
        end
    end

endmodule

`default_nettype wire

// File: logic/sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module sequencer #(
    parameter cpu_bus_pkg::addr_t RESET_PC = 16'h0200
) (
    input  logic                clk,
    input  logic                reset,
    input  cpu_bus_pkg::data_t  rdata,
    input  cpu_isa_pkg::ctrl_t  dec,
    output cpu_isa_pkg::state_t state,
    output cpu_bus_pkg::addr_t  pc,         // Fetch address for this cycle
    output cpu_isa_pkg::ctrl_t  ctrl
);

    cpu_bus_pkg::addr_t pc_q;               // Address of next byte to read
    cpu_bus_pkg::data_t jmp_lo;             // JMP target low byte

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_isa_pkg::FETCH;    // First FETCH reads opcode at RESET_PC
            pc_q  <= RESET_PC;
            ctrl  <= '0;
        end else begin
            case (state)
                cpu_isa_pkg::DECODE: begin
                    state <= dec.next;
                    ctrl  <= dec;
                    // Implied ops reread this byte in REG as the next opcode
                    if (dec.next != cpu_isa_pkg::REG)
                        pc_q <= pc_q + 16'd1;
                end
                cpu_isa_pkg::FETCH: begin
                    state <= cpu_isa_pkg::DECODE;
                    pc_q  <= pc_q + 16'd1;
                end
                cpu_isa_pkg::REG: begin
                    state <= cpu_isa_pkg::DECODE;
                    pc_q  <= pc_q + 16'd1;
                end
                cpu_isa_pkg::ZP0:
                    state <= cpu_isa_pkg::FETCH;    // pc_q already at next opcode
                cpu_isa_pkg::JMP0: begin
                    state <= cpu_isa_pkg::JMP1;
                    pc_q  <= pc_q + 16'd1;
                end
                cpu_isa_pkg::JMP1: begin
                    state <= cpu_isa_pkg::DECODE;
                    pc_q  <= {rdata, jmp_lo} + 16'd1;   // Target fetched this cycle
                end
                default:
                    state <= cpu_isa_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_isa_pkg::JMP0)
            jmp_lo <= rdata;                // Operand low byte
    end

    // JMP1 puts the target on the bus directly, saving a cycle
    always_comb begin
        if (state == cpu_isa_pkg::JMP1)
            pc = {rdata, jmp_lo};
        else
            pc = pc_q;
    end

endmodule

`default_nettype wire

// File: logic/alu_regs.sv
`default_nettype none
`timescale 1ns/1ps

module alu_regs (
    input  logic                clk,
    input  logic                reset,
    input  cpu_isa_pkg::state_t state,
    input  cpu_isa_pkg::ctrl_t  ctrl,       // Controls of instruction in flight
    input  cpu_bus_pkg::data_t  rdata,
    output cpu_bus_pkg::data_t  reg_out
);

    cpu_bus_pkg::data_t   regs [0:2];       // A, X, Y
    cpu_isa_pkg::reg_sel_t regsel;
    cpu_bus_pkg::data_t   ai;               // ALU A input
    cpu_bus_pkg::data_t   bi;               // ALU B input
    logic                 ci;
    cpu_isa_pkg::alu_op_t op;
    cpu_bus_pkg::data_t   logic_res;
    cpu_bus_pkg::data_t   b_term;
    logic                 adder_ci;
    logic [8:0]           sum;
    cpu_bus_pkg::data_t   alu_out;          // Registered result
    logic                 carry_out;
    logic                 c_flag;
    logic                 adc_sbc;

    // Destination is addressed only in the write cycle
    assign regsel  = (state == cpu_isa_pkg::DECODE) ? ctrl.dst_reg : ctrl.src_reg;
    assign reg_out = regs[regsel];

    always_comb begin
        ai = '0;                            // Plain pass of rdata elsewhere
        bi = rdata;
        ci = 1'b0;
        op = cpu_isa_pkg::OP_ADD;
        case (state)
            cpu_isa_pkg::REG: begin         // Transfers, INx, DEx
                ai = reg_out;
                bi = '0;
                ci = ctrl.inc;
                op = ctrl.op;
            end
            cpu_isa_pkg::FETCH: begin       // Operand byte on rdata
                ai = ctrl.load_only ? 8'h00 : reg_out;
                ci = ctrl.compare ? 1'b1 : (ctrl.load_only ? 1'b0 : c_flag);
                op = ctrl.op;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op[1:0])
            2'b00:   logic_res = ai | bi;
            2'b01:   logic_res = ai & bi;
            2'b10:   logic_res = ai ^ bi;
            default: logic_res = ai;
        endcase
        case (op[3:2])
            2'b00:   b_term = bi;           // A + B
            2'b01:   b_term = ~bi;          // A - B
            default: b_term = '0;           // Logic result only
        endcase
        adder_ci = (op[3:2] == 2'b11) ? 1'b0 : ci;
        sum = {1'b0, logic_res} + {1'b0, b_term} + {8'b0, adder_ci};
    end

    always_ff @(posedge clk) begin
        alu_out   <= sum[7:0];
        carry_out <= sum[8];
    end

    always_ff @(posedge clk) begin
        if (state == cpu_isa_pkg::DECODE && ctrl.load_reg)
            regs[regsel] <= alu_out;        // Write back one cycle behind the ALU
    end

    // ADC/SBC are the non-load adder ops that run in FETCH
    assign adc_sbc = (ctrl.next == cpu_isa_pkg::FETCH) && !ctrl.load_only
                     && !ctrl.compare && !ctrl.op[3];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_flag <= 1'b0;
        end else if (state == cpu_isa_pkg::DECODE) begin
            if (adc_sbc || ctrl.compare)
                c_flag <= carry_out;
        end else if (state == cpu_isa_pkg::REG) begin
            if (ctrl.set_c)
                c_flag <= 1'b1;
            if (ctrl.clr_c)
                c_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/bus_drive.sv
`default_nettype none
`timescale 1ns/1ps

module bus_drive (
    input  cpu_isa_pkg::state_t    state,
    input  cpu_isa_pkg::ctrl_t     ctrl,
    input  cpu_bus_pkg::addr_t     pc,
    input  cpu_bus_pkg::data_t     rdata,       // Zero-page operand in ZP0
    input  cpu_bus_pkg::data_t     reg_out,
    output cpu_bus_pkg::mem_req_t  req
);

    always_comb begin
        req.wdata = reg_out;                    // Source register, used only on stores
        if (state == cpu_isa_pkg::ZP0) begin
            req.addr = {cpu_bus_pkg::zp_page, rdata};
            req.we   = ctrl.store;              // Loads read the same address
        end else begin
            req.addr = pc;
            req.we   = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_bus_pkg::addr_t RESET_PC = 16'h0200      // First opcode address
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_bus_pkg::addr_t addr,
    input  cpu_bus_pkg::data_t rdata,                       // Byte for last cycle's addr
    output cpu_bus_pkg::data_t wdata,
    output logic               we
);

    cpu_isa_pkg::ctrl_t   dec;              // Decoded straight off rdata
    cpu_isa_pkg::ctrl_t   ctrl;             // Latched in DECODE
    cpu_isa_pkg::state_t  state;
    cpu_bus_pkg::addr_t   pc;
    cpu_bus_pkg::data_t   reg_out;          // Selected register
    cpu_bus_pkg::mem_req_t req;

    instr_decode u_decode (.rdata(rdata), .dec(dec));

    sequencer #(.RESET_PC(RESET_PC)) u_seq (
        .clk(clk), .reset(reset), .rdata(rdata), .dec(dec),
        .state(state), .pc(pc), .ctrl(ctrl)
    );

    alu_regs u_alu (
        .clk(clk), .reset(reset), .state(state), .ctrl(ctrl),
        .rdata(rdata), .reg_out(reg_out)
    );

    bus_drive u_bus (
        .state(state), .ctrl(ctrl), .pc(pc), .rdata(rdata),
        .reg_out(reg_out), .req(req)
    );

    assign addr  = req.addr;
    assign wdata = req.wdata;
    assign we    = req.we;

endmodule

`default_nettype wire

// File: bench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [7:0]  model_a;                       // Architectural registers
logic [7:0]  model_x;
logic [7:0]  model_y;
logic        model_c;
logic [7:0]  zp_image [0:255];              // Zero page as the model sees it
logic [15:0] exp_addr [$];                  // Expected write bus, in order
logic [7:0]  exp_data [$];
logic [15:0] exp_halt;                      // Address of the JMP to itself

// Bytes per instruction, unknown opcodes take one
function automatic int instr_len(input logic [7:0] op);
    case (op)
        cpu_isa_pkg::OPC_JMP_ABS: return 3;
        cpu_isa_pkg::OPC_LDA_IMM, cpu_isa_pkg::OPC_LDX_IMM, cpu_isa_pkg::OPC_LDY_IMM,
        cpu_isa_pkg::OPC_ORA_IMM, cpu_isa_pkg::OPC_AND_IMM, cpu_isa_pkg::OPC_EOR_IMM,
        cpu_isa_pkg::OPC_ADC_IMM, cpu_isa_pkg::OPC_SBC_IMM, cpu_isa_pkg::OPC_CMP_IMM,
        cpu_isa_pkg::OPC_LDA_ZP, cpu_isa_pkg::OPC_LDX_ZP, cpu_isa_pkg::OPC_LDY_ZP,
        cpu_isa_pkg::OPC_STA_ZP, cpu_isa_pkg::OPC_STX_ZP, cpu_isa_pkg::OPC_STY_ZP:
            return 2;
        default: return 1;
    endcase
endfunction

task automatic model_store(input logic [7:0] zp, input logic [7:0] val);
    zp_image[zp] = val;
    exp_addr.push_back({8'h00, zp});
    exp_data.push_back(val);
endtask

// Instruction-level run from start until a JMP to itself
task automatic run_model(input logic [15:0] start, output bit halted);
    logic [15:0] pc;
    logic [7:0]  op;
    logic [7:0]  arg;
    int          steps;
    pc = start;
    halted = 1'b0;
    model_c = 1'b0;                         // Carry clears on reset
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++)
        zp_image[i] = mem[i];
    for (steps = 0; steps < 4096 && !halted; steps++) begin
        op  = mem[pc];
        arg = mem[pc + 16'd1];
        if (op == cpu_isa_pkg::OPC_JMP_ABS && {mem[pc + 16'd2], arg} == pc) begin
            halted   = 1'b1;
            exp_halt = pc;
        end else if (op == cpu_isa_pkg::OPC_JMP_ABS) begin
            pc = {mem[pc + 16'd2], arg};
        end else begin
            case (op)
                cpu_isa_pkg::OPC_TAX:     model_x = model_a;
                cpu_isa_pkg::OPC_TXA:     model_a = model_x;
                cpu_isa_pkg::OPC_TAY:     model_y = model_a;
                cpu_isa_pkg::OPC_TYA:     model_a = model_y;
                cpu_isa_pkg::OPC_INX:     model_x = model_x + 8'd1;
                cpu_isa_pkg::OPC_INY:     model_y = model_y + 8'd1;
                cpu_isa_pkg::OPC_DEX:     model_x = model_x - 8'd1;
                cpu_isa_pkg::OPC_DEY:     model_y = model_y - 8'd1;
                cpu_isa_pkg::OPC_CLC:     model_c = 1'b0;
                cpu_isa_pkg::OPC_SEC:     model_c = 1'b1;
                cpu_isa_pkg::OPC_LDA_IMM: model_a = arg;
                cpu_isa_pkg::OPC_LDX_IMM: model_x = arg;
                cpu_isa_pkg::OPC_LDY_IMM: model_y = arg;
                cpu_isa_pkg::OPC_ORA_IMM: model_a = model_a | arg;
                cpu_isa_pkg::OPC_AND_IMM: model_a = model_a & arg;
                cpu_isa_pkg::OPC_EOR_IMM: model_a = model_a ^ arg;
                cpu_isa_pkg::OPC_ADC_IMM: {model_c, model_a} = model_a + arg + model_c;
                // Carry out means no borrow
                cpu_isa_pkg::OPC_SBC_IMM: {model_c, model_a} = 9'h100 + model_a - arg - !model_c;
                cpu_isa_pkg::OPC_CMP_IMM: model_c = (model_a >= arg);
                cpu_isa_pkg::OPC_LDA_ZP:  model_a = zp_image[arg];
                cpu_isa_pkg::OPC_LDX_ZP:  model_x = zp_image[arg];
                cpu_isa_pkg::OPC_LDY_ZP:  model_y = zp_image[arg];
                cpu_isa_pkg::OPC_STA_ZP:  model_store(arg, model_a);
                cpu_isa_pkg::OPC_STX_ZP:  model_store(arg, model_x);
                cpu_isa_pkg::OPC_STY_ZP:  model_store(arg, model_y);
                default: ;                  // Unknown opcode acts as NOP
            endcase
            pc = pc + 16'(instr_len(op));
        end
    end
endtask

`endif

// File: bench/cpu_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_core_tb;

    localparam logic [15:0] START   = 16'h0200;    // RESET_PC given to the DUT
    localparam int          TIMEOUT = 1000;        // Cycles allowed to reach the halt

    logic        clk   = 1'b0;
    logic        reset = 1'b1;
    logic [7:0]  rdata = 8'h00;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        we;
    logic [7:0]  mem [0:65535];
    logic [15:0] got_addr [$];              // Writes seen on the bus
    logic [7:0]  got_data [$];
    logic [7:0]  prog [$];                  // Program bytes from START
    logic [7:0]  pool [$];                  // Opcodes for the current test
    int          errors       = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    `include "cpu_model.svh"

    cpu_core #(.RESET_PC(START)) dut (
        .clk(clk), .reset(reset), .addr(addr), .rdata(rdata), .wdata(wdata), .we(we)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin             // Synchronous RAM
        rdata <= mem[addr];
        if (we)
            mem[addr] <= wdata;
    end

    always @(negedge clk) begin
        if (!reset && we) begin
            got_addr.push_back(addr);
            got_data.push_back(wdata);
        end
    end

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ {a[14:8], a[15]} ^ 8'h3C;   // Every address bit counts
    endfunction

    function automatic logic [15:0] imm_value(input bit near_wrap);
        if (near_wrap)
            return 16'(8'(($urandom % 4) - 2));     // FE, FF, 00 or 01
        return 16'(8'($urandom));
    endfunction

    task automatic emit(input logic [7:0] op, input logic [15:0] arg);
        prog.push_back(op);
        if (instr_len(op) > 1)
            prog.push_back(arg[7:0]);
        if (instr_len(op) > 2)
            prog.push_back(arg[15:8]);
    endtask

    // Loads all three registers, then count random picks from pool
    task automatic build_program(input int count, input bit near_wrap);
        logic [7:0] op;
        prog.delete();
        emit(cpu_isa_pkg::OPC_LDA_IMM, imm_value(near_wrap));
        emit(cpu_isa_pkg::OPC_LDX_IMM, imm_value(near_wrap));
        emit(cpu_isa_pkg::OPC_LDY_IMM, imm_value(near_wrap));
        repeat (count) begin
            op = pool[$urandom % pool.size()];
            if (op inside {cpu_isa_pkg::OPC_LDA_ZP, cpu_isa_pkg::OPC_LDX_ZP,
                           cpu_isa_pkg::OPC_LDY_ZP, cpu_isa_pkg::OPC_STA_ZP,
                           cpu_isa_pkg::OPC_STX_ZP, cpu_isa_pkg::OPC_STY_ZP})
                emit(op, 16'(8'h80 | 8'($urandom)));   // Upper half of zero page
            else
                emit(op, imm_value(near_wrap));
        end
    endtask

    task automatic finish_program();
        emit(cpu_isa_pkg::OPC_STA_ZP, 16'h0010);
        emit(cpu_isa_pkg::OPC_STX_ZP, 16'h0011);
        emit(cpu_isa_pkg::OPC_STY_ZP, 16'h0012);
        emit(cpu_isa_pkg::OPC_JMP_ABS, START + 16'(prog.size()));   // Halt loop
    endtask

    task automatic run_program(input string name);
        bit halted;
        int hits;
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 256; i++)
            mem[i] = fill_byte(16'(i));
        foreach (prog[i])
            mem[START + 16'(i)] = prog[i];
        got_addr.delete();
        got_data.delete();
        run_model(START, halted);
        assert (halted) else begin
            $display("%s: reference model never reached a halt", name);
            test_errors++;
        end
        for (int c = 0; c < 16; c++) begin
            if (c > 0)
                @(negedge clk);
            assert (we === 1'b0 && addr === START) else begin
                $display("[FAIL] %s reset bus expected we=0 addr=%h actual we=%b addr=%h",
                         name, START, we, addr);
                test_errors++;
            end
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);
        assert (addr === START) else begin  // First fetch after reset
            $display("[FAIL] %s first fetch expected %h actual %h", name, START, addr);
            test_errors++;
        end
        hits = 0;
        for (cycles = 0; cycles < TIMEOUT && hits < 2; cycles++) begin
            @(negedge clk);
            if (addr === exp_halt)
                hits++;
        end
        assert (hits == 2) else begin
            $display("%s: no halt at %h within %0d cycles", name, exp_halt, TIMEOUT);
            test_errors++;
        end
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("[FAIL] %s write count expected %0d actual %0d",
                     name, exp_addr.size(), got_addr.size());
            test_errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            assert (got_addr[i] === exp_addr[i] && got_data[i] === exp_data[i]) else begin
                $display("[FAIL] %s write %0d expected %h=%h actual %h=%h", name, i,
                         exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
                test_errors++;
            end
        end
    endtask

    task automatic random_batch(input string name, input int programs, input int max_len,
                                input bit near_wrap);
        repeat (programs) begin
            build_program(2 + $urandom % max_len, near_wrap);
            finish_program();
            run_program(name);
        end
    endtask

    task automatic report_test(input string name, input int programs);
        $display("%-12s %0d programs, %0d errors", name, programs, test_errors);
        errors += test_errors;
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(32'h35ce_e580));
        for (int i = 0; i < 65536; i++)
            mem[i] = fill_byte(16'(i));

        pool = '{cpu_isa_pkg::OPC_LDA_ZP, cpu_isa_pkg::OPC_STA_ZP};
        random_batch("reset", 1, 2, 1'b0);
        report_test("reset", 1);

        pool = '{cpu_isa_pkg::OPC_LDA_IMM, cpu_isa_pkg::OPC_LDX_IMM, cpu_isa_pkg::OPC_LDY_IMM,
                 cpu_isa_pkg::OPC_LDA_ZP, cpu_isa_pkg::OPC_LDX_ZP, cpu_isa_pkg::OPC_LDY_ZP,
                 cpu_isa_pkg::OPC_STA_ZP, cpu_isa_pkg::OPC_STX_ZP, cpu_isa_pkg::OPC_STY_ZP};
        random_batch("load_store", 20, 12, 1'b0);
        report_test("load_store", 20);

        pool = '{cpu_isa_pkg::OPC_ADC_IMM, cpu_isa_pkg::OPC_ADC_IMM, cpu_isa_pkg::OPC_SBC_IMM,
                 cpu_isa_pkg::OPC_CMP_IMM, cpu_isa_pkg::OPC_CLC, cpu_isa_pkg::OPC_SEC,
                 cpu_isa_pkg::OPC_ORA_IMM, cpu_isa_pkg::OPC_AND_IMM, cpu_isa_pkg::OPC_EOR_IMM,
                 cpu_isa_pkg::OPC_STA_ZP};
        random_batch("arith_flags", 40, 18, 1'b0);
        report_test("arith_flags", 40);

        pool = '{cpu_isa_pkg::OPC_TAX, cpu_isa_pkg::OPC_TXA, cpu_isa_pkg::OPC_TAY,
                 cpu_isa_pkg::OPC_TYA, cpu_isa_pkg::OPC_INX, cpu_isa_pkg::OPC_INY,
                 cpu_isa_pkg::OPC_DEX, cpu_isa_pkg::OPC_DEY, cpu_isa_pkg::OPC_LDX_IMM,
                 cpu_isa_pkg::OPC_LDY_IMM};
        random_batch("transfers", 20, 22, 1'b1);    // Start values near wraparound
        report_test("transfers", 20);

        build_program(0, 1'b0);                     // JMP over five stores
        emit(cpu_isa_pkg::OPC_JMP_ABS, START + 16'(prog.size()) + 16'd13);
        for (int i = 0; i < 5; i++)
            emit(cpu_isa_pkg::OPC_STA_ZP, 16'h0020 + 16'(i));
        emit(cpu_isa_pkg::OPC_INX, 16'h0000);
        finish_program();
        run_program("jmp");
        foreach (got_addr[i]) begin
            assert (got_addr[i] < 16'h0020 || got_addr[i] > 16'h0024) else begin
                $display("jmp: a store inside the skipped block reached the write bus");
                test_errors++;
            end
        end
        report_test("jmp", 1);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_core.f
+incdir+bench
logic/cpu_bus_pkg.sv
logic/cpu_isa_pkg.sv
logic/instr_decode.sv
logic/sequencer.sv
logic/alu_regs.sv
logic/bus_drive.sv
logic/cpu_core.sv
bench/cpu_core_tb.sv
